// ==== src/fft_frame_pkg.sv ====
`default_nettype none

package fft_frame_pkg;

	// one signed real or imaginary part of a complex sample
	typedef logic signed [15:0] sample_part_t;

	// re*re + im*im of a full scale sample
	// worst case is two times 2**30 so one bit above 32
	typedef logic [32:0] power_t;

	// samples per analysis window
	localparam int DEF_WINDOW_SIZE = 512;

	// samples between two window starts
	// windows overlap by size minus step
	localparam int DEF_WINDOW_STEP = 160;

	// windows produced per trigger
	localparam int DEF_FRAMES_PER_RUN = 100;

	// lower bins kept per window
	// dc up to nyquist of a 512 point transform
	localparam int DEF_KEEP_BINS = 257;

	// sample buffer read latency in clock cycles
	// address register plus output register
	localparam int RAM_READ_LATENCY = 2;

	// capture sequencer states
	typedef enum logic {
		wait_trigger,
		active
	} seq_state_t;

endpackage

`default_nettype wire

// ==== src/sample_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// read-out samples from the sequencer toward the power stage
// no ready here since the sequencer never pauses
interface sample_stream_if;
	import fft_frame_pkg::*;

	// real and imaginary part of one buffered sample
	sample_part_t re_part;
	sample_part_t im_part;

	// high on the final sample of a window
	logic last;

	// one item per cycle while high
	logic valid;

	// sequencer side
	modport source (output re_part, im_part, last, valid);

	// power stage side
	modport sink (input re_part, im_part, last, valid);

endinterface

`default_nettype wire

// ==== src/frame_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

// simple two-port sample buffer
// one write port and one read port on a common clock
module frame_ram #(
	parameter int DEPTH = 1024,
	parameter int DATA_WIDTH = 32,
	localparam int ADDR_W = $clog2(DEPTH)
) (
	input var logic clk,
	input var logic arstn,
	input var logic we_i,
	input var logic [ADDR_W-1:0] waddr_i,
	input var logic [DATA_WIDTH-1:0] wdata_i,
	input var logic re_i,
	input var logic [ADDR_W-1:0] raddr_i,
	output var logic [DATA_WIDTH-1:0] rdata_o
);
	typedef logic [DATA_WIDTH-1:0] word_t;

	// storage array of packed re/im pairs
	word_t mem [DEPTH];

	// first read stage
	word_t rd_stage;

	// write port
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// array read only when enabled
	always_ff @(posedge clk) begin
		if (re_i) begin
			rd_stage <= mem[raddr_i];
		end
	end

	// output register runs every cycle
	// two cycles from re_i to data
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= rd_stage;
		end
	end

endmodule

`default_nettype wire

// ==== src/stream_register.sv ====
`timescale 1ns/100ps
`default_nettype none

// single slot valid/ready pipeline stage
module stream_register #(
	parameter type data_t = logic
) (
	input var logic clk,
	input var logic arstn,
	input var data_t data_i,
	input var logic valid_i,
	output var logic ready_o,
	output var data_t data_o,
	output var logic valid_o,
	input var logic ready_i
);

	// slot can take a new item when empty
	// or when its current item leaves this cycle
	assign ready_o = ready_i || !valid_o;

	// payload loads on a transfer in
	always_ff @(posedge clk) begin
		if (valid_i && ready_o) begin
			data_o <= data_i;
		end
	end

	// occupancy
	// held while downstream stalls
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			valid_o <= 1'b0;
		end else if (ready_o) begin
			valid_o <= valid_i;
		end
	end

endmodule

`default_nettype wire

// ==== src/power_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

// per-sample power re^2 + im^2 behind one stream register
module power_calc (
	input var logic clk,
	input var logic arstn,
	input var logic ready_i,
	sample_stream_if.sink stream_i,
	output var fft_frame_pkg::power_t power_o,
	output var logic last_o,
	output var logic valid_o
);
	import fft_frame_pkg::*;

	// power with the window last flag on top
	typedef logic [$bits(power_t):0] beat_t;

	logic signed [2*$bits(sample_part_t)-1:0] re_sq, im_sq;
	power_t power;
	beat_t beat_in, beat_out;

	// signed squares, never negative
	assign re_sq = stream_i.re_part * stream_i.re_part;
	assign im_sq = stream_i.im_part * stream_i.im_part;

	// zero extend before the sum so full scale cannot wrap
	assign power = {1'b0, re_sq} + {1'b0, im_sq};

	assign beat_in = {stream_i.last, power};

	// upstream has no ready
	// so the register's ready output goes nowhere
	stream_register #(
		.data_t(beat_t)
	) u_stream_register (
		.clk(clk),
		.arstn(arstn),
		.data_i(beat_in),
		.valid_i(stream_i.valid),
		.ready_o(),
		.data_o(beat_out),
		.valid_o(valid_o),
		.ready_i(ready_i)
	);

	assign {last_o, power_o} = beat_out;

endmodule

`default_nettype wire

// ==== src/bin_select.sv ====
`timescale 1ns/100ps
`default_nettype none

// keeps the lower bins of each window and drops the rest
module bin_select #(
	parameter int KEEP_BINS = fft_frame_pkg::DEF_KEEP_BINS
) (
	input var logic clk,
	input var logic arstn,
	input var fft_frame_pkg::power_t power_i,
	input var logic last_i,
	input var logic valid_i,
	output var logic ready_o,
	output var fft_frame_pkg::power_t power_o,
	output var logic last_o,
	output var logic valid_o,
	input var logic ready_i
);
	// index saturates at KEEP_BINS
	localparam int BIN_CNT_W = $clog2(KEEP_BINS + 1);

	typedef logic [BIN_CNT_W-1:0] bin_idx_t;

	bin_idx_t bin_idx;
	logic keep;

	// bin index within the current window
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			bin_idx <= '0;
		end else if (valid_i && ready_o) begin
			if (last_i) begin
				bin_idx <= '0;
			end else if (keep) begin
				bin_idx <= bin_idx + 1'b1;
			end
		end
	end

	assign keep = (bin_idx < BIN_CNT_W'(KEEP_BINS));

	// upper bins are swallowed here without reaching the output
	assign power_o = power_i;
	assign valid_o = valid_i && keep;
	assign ready_o = ready_i || !keep;

	// new last on the final kept bin
	assign last_o = (bin_idx == BIN_CNT_W'(KEEP_BINS - 1));

endmodule

`default_nettype wire

// ==== src/frame_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

// trigger started capture into a ring of two windows
// plus read-out of overlapping windows for a fixed number of frames
module frame_sequencer #(
	parameter int WINDOW_SIZE = fft_frame_pkg::DEF_WINDOW_SIZE,
	parameter int WINDOW_STEP = fft_frame_pkg::DEF_WINDOW_STEP,
	parameter int FRAMES_PER_RUN = fft_frame_pkg::DEF_FRAMES_PER_RUN
) (
	input var logic clk,
	input var logic arstn,
	input var logic trigger_i,
	input var fft_frame_pkg::sample_part_t data_re_i,
	input var fft_frame_pkg::sample_part_t data_im_i,
	input var logic data_valid_i,
	output var logic active_o,
	sample_stream_if.source stream_o
);
	import fft_frame_pkg::*;

	// ring depth and derived widths
	localparam int DEPTH = 2 * WINDOW_SIZE;
	localparam int ADDR_W = $clog2(DEPTH);
	localparam int SAMPLE_CNT_W = $clog2(WINDOW_SIZE);
	localparam int FRAME_CNT_W = $clog2(FRAMES_PER_RUN + 1);
	localparam int FILL_W = $clog2(DEPTH + 1);
	localparam int PAIR_W = 2 * $bits(sample_part_t);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PAIR_W-1:0] pair_t;

	seq_state_t state, state_next;
	addr_t waddr, raddr, raddr_base, base_next;
	pair_t rdata;
	logic we, re;
	logic rlast, window_last, done;
	logic [SAMPLE_CNT_W-1:0] sample_cnt;
	logic [FRAME_CNT_W-1:0] frame_cnt;
	logic [FILL_W-1:0] fill_cnt;
	logic [RAM_READ_LATENCY-1:0] valid_pipe, last_pipe;

	// state register
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			state <= wait_trigger;
		end else begin
			state <= state_next;
		end
	end

	// trigger starts a run, last sample of last frame ends it
	always_comb begin
		state_next = state;
		case (state)
			wait_trigger: if (trigger_i) state_next = active;
			active: if (done) state_next = wait_trigger;
			default: state_next = wait_trigger;
		endcase
	end

	assign active_o = (state == active);

	// capture every valid sample while a run is open
	assign we = data_valid_i && (state == active);

	// write pointer restarts at 0 for each run
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			waddr <= '0;
		end else if (state == wait_trigger) begin
			waddr <= '0;
		end else if (we) begin
			waddr <= (waddr == addr_t'(DEPTH - 1)) ? '0 : waddr + 1'b1;
		end
	end

	// position inside the current window
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			sample_cnt <= '0;
		end else if (state == wait_trigger) begin
			sample_cnt <= '0;
		end else if (re) begin
			sample_cnt <= rlast ? '0 : sample_cnt + 1'b1;
		end
	end

	assign rlast = (sample_cnt == SAMPLE_CNT_W'(WINDOW_SIZE - 1));
	assign window_last = re && rlast;

	// windows finished in this run
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			frame_cnt <= '0;
		end else if (state == wait_trigger) begin
			frame_cnt <= '0;
		end else if (window_last) begin
			frame_cnt <= done ? '0 : frame_cnt + 1'b1;
		end
	end

	assign done = window_last && (frame_cnt == FRAME_CNT_W'(FRAMES_PER_RUN - 1));

	// next window start, one step on and wrapped into the ring
	always_comb begin
		if (int'(raddr_base) < DEPTH - WINDOW_STEP) begin
			base_next = raddr_base + addr_t'(WINDOW_STEP);
		end else begin
			base_next = raddr_base - addr_t'(DEPTH - WINDOW_STEP);
		end
	end

	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			raddr_base <= '0;
		end else if (state == wait_trigger) begin
			raddr_base <= '0;
		end else if (window_last) begin
			raddr_base <= base_next;
		end
	end

	// read pointer walks the window then jumps back to the new base
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			raddr <= '0;
		end else if (state == wait_trigger) begin
			raddr <= '0;
		end else if (re) begin
			if (window_last) begin
				raddr <= base_next;
			end else begin
				raddr <= (raddr == addr_t'(DEPTH - 1)) ? '0 : raddr + 1'b1;
			end
		end
	end

	// samples held from the window base onward
	// grows per write and drops by one step per finished window
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			fill_cnt <= '0;
		end else if (state == wait_trigger) begin
			fill_cnt <= '0;
		end else begin
			case ({we, window_last})
				2'b10: fill_cnt <= fill_cnt + 1'b1;
				2'b01: fill_cnt <= fill_cnt - FILL_W'(WINDOW_STEP);
				2'b11: fill_cnt <= fill_cnt + 1'b1 - FILL_W'(WINDOW_STEP);
				default: fill_cnt <= fill_cnt;
			endcase
		end
	end

	// read only behind the write pointer
	assign re = (state == active) && (fill_cnt != '0) && (raddr != waddr);

	frame_ram #(
		.DEPTH(DEPTH),
		.DATA_WIDTH(PAIR_W)
	) u_frame_ram (
		.clk(clk),
		.arstn(arstn),
		.we_i(we),
		.waddr_i(waddr),
		.wdata_i({data_re_i, data_im_i}),
		.re_i(re),
		.raddr_i(raddr),
		.rdata_o(rdata)
	);

	// valid and last follow the ram latency, then the output register
	// cleared once the run is over so in-flight reads are dropped
	always_ff @(posedge clk or negedge arstn) begin
		if (!arstn) begin
			valid_pipe <= '0;
			last_pipe <= '0;
			stream_o.valid <= 1'b0;
			stream_o.last <= 1'b0;
		end else if (state == wait_trigger) begin
			valid_pipe <= '0;
			last_pipe <= '0;
			stream_o.valid <= 1'b0;
			stream_o.last <= 1'b0;
		end else begin
			valid_pipe <= {valid_pipe[RAM_READ_LATENCY-2:0], re};
			last_pipe <= {last_pipe[RAM_READ_LATENCY-2:0], window_last};
			stream_o.valid <= valid_pipe[RAM_READ_LATENCY-1];
			stream_o.last <= last_pipe[RAM_READ_LATENCY-1];
		end
	end

	// sample output register, lines up with stream_o.valid
	always_ff @(posedge clk) begin
		{stream_o.re_part, stream_o.im_part} <= rdata;
	end

endmodule

`default_nettype wire

// ==== src/spectrum_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

// spectrum analyser front end
// capture, overlapping windows, power, lower bins
module spectrum_frontend #(
	parameter int WINDOW_SIZE = fft_frame_pkg::DEF_WINDOW_SIZE,
	parameter int WINDOW_STEP = fft_frame_pkg::DEF_WINDOW_STEP,
	parameter int FRAMES_PER_RUN = fft_frame_pkg::DEF_FRAMES_PER_RUN,
	parameter int KEEP_BINS = fft_frame_pkg::DEF_KEEP_BINS
) (
	input var logic clk,
	input var logic arstn,
	input var logic trigger_i,
	input var fft_frame_pkg::sample_part_t data_re_i,
	input var fft_frame_pkg::sample_part_t data_im_i,
	input var logic data_valid_i,
	input var logic proc_data_ready_i,
	output var fft_frame_pkg::power_t proc_data_o,
	output var logic proc_data_last_o,
	output var logic proc_data_valid_o,
	output var logic active_o
);
	import fft_frame_pkg::*;

	// power stage to bin selector
	power_t power;
	logic power_last;
	logic power_valid;
	logic power_ready;

	// windowed samples out of the buffer
	sample_stream_if u_stream_if ();

	frame_sequencer #(
		.WINDOW_SIZE(WINDOW_SIZE),
		.WINDOW_STEP(WINDOW_STEP),
		.FRAMES_PER_RUN(FRAMES_PER_RUN)
	) u_frame_sequencer (
		.clk(clk),
		.arstn(arstn),
		.trigger_i(trigger_i),
		.data_re_i(data_re_i),
		.data_im_i(data_im_i),
		.data_valid_i(data_valid_i),
		.active_o(active_o),
		.stream_o(u_stream_if.source)
	);

	power_calc u_power_calc (
		.clk(clk),
		.arstn(arstn),
		.ready_i(power_ready),
		.stream_i(u_stream_if.sink),
		.power_o(power),
		.last_o(power_last),
		.valid_o(power_valid)
	);

	// output ready lands here
	// the sequencer itself never stalls
	bin_select #(
		.KEEP_BINS(KEEP_BINS)
	) u_bin_select (
		.clk(clk),
		.arstn(arstn),
		.power_i(power),
		.last_i(power_last),
		.valid_i(power_valid),
		.ready_o(power_ready),
		.power_o(proc_data_o),
		.last_o(proc_data_last_o),
		.valid_o(proc_data_valid_o),
		.ready_i(proc_data_ready_i)
	);

endmodule

`default_nettype wire

// ==== dv/spectrum_frontend_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spectrum_frontend_tb;
	import fft_frame_pkg::*;

	// small frame so one run takes a few hundred cycles
	localparam int WINDOW_SIZE = 8;
	localparam int WINDOW_STEP = 4;
	localparam int FRAMES_PER_RUN = 3;
	localparam int KEEP_BINS = 5;
	localparam string TEST_FILE = "dv/spectrum_frontend_tests.txt";

	logic clk;
	logic arstn;
	logic trigger_i;
	sample_part_t data_re_i;
	sample_part_t data_im_i;
	logic data_valid_i;
	logic proc_data_ready_i;
	power_t proc_data_o;
	logic proc_data_last_o;
	logic proc_data_valid_o;
	logic active_o;

	// input samples and expected outputs, each tagged with its run
	int samp_run[$];
	int samp_re[$];
	int samp_im[$];
	int exp_run[$];
	longint exp_pow[$];
	int exp_last[$];
	int num_runs;

	int errors;
	int out_idx;
	int run_outputs;
	int cur_run;
	// high while no output may appear
	logic quiet;
	// low once a run hit a timeout
	logic run_ok;
	logic [31:0] lfsr;

	spectrum_frontend #(
		.WINDOW_SIZE(WINDOW_SIZE),
		.WINDOW_STEP(WINDOW_STEP),
		.FRAMES_PER_RUN(FRAMES_PER_RUN),
		.KEEP_BINS(KEEP_BINS)
	) u_dut (
		.clk(clk),
		.arstn(arstn),
		.trigger_i(trigger_i),
		.data_re_i(data_re_i),
		.data_im_i(data_im_i),
		.data_valid_i(data_valid_i),
		.proc_data_ready_i(proc_data_ready_i),
		.proc_data_o(proc_data_o),
		.proc_data_last_o(proc_data_last_o),
		.proc_data_valid_o(proc_data_valid_o),
		.active_o(active_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic compare(input logic [63:0] got, input logic [63:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			errors = errors + 1;
		end
	endtask

	task automatic finish_sim();
		$display("%0d errors, %0d outputs checked", errors, out_idx);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	task automatic load_tests();
		int fd;
		int n;
		int run;
		string line;
		longint v [10];
		run = -1;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("could not open %s", TEST_FILE);
			errors = errors + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 0) begin
					case (line.getc(0))
						"t": run = run + 1;
						// four re/im pairs per line
						"s": begin
							n = $sscanf(line, "s %d %d %d %d %d %d %d %d",
								v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
							if (n != 8) begin
								$display("sample line with %0d values in %s", n, TEST_FILE);
								errors = errors + 1;
							end
							for (int i = 0; i < 4; i++) begin
								samp_run.push_back(run);
								samp_re.push_back(int'(v[2*i]));
								samp_im.push_back(int'(v[2*i+1]));
							end
						end
						// one window of power/last pairs
						"e": begin
							n = $sscanf(line, "e %d %d %d %d %d %d %d %d %d %d",
								v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
							if (n != 10) begin
								$display("expected line with %0d values in %s", n, TEST_FILE);
								errors = errors + 1;
							end
							for (int i = 0; i < 5; i++) begin
								exp_run.push_back(run);
								exp_pow.push_back(v[2*i]);
								exp_last.push_back(int'(v[2*i+1]));
							end
						end
						default: ;
					endcase
				end
			end
			$fclose(fd);
		end
		num_runs = run + 1;
		if (num_runs == 0) begin
			$display("no runs found in %s", TEST_FILE);
			errors = errors + 1;
		end
	endtask

	// data without a trigger, must not start a run
	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			data_valid_i = i[0];
			data_re_i = sample_part_t'(16'h5a5a);
			data_im_i = sample_part_t'(-i);
			@(posedge clk);
			#10;
			compare(active_o, 1'b0, "active_o while idle");
		end
		data_valid_i = 1'b0;
	endtask

	task automatic run_once(input int r, output logic completed);
		int k;
		int cnt;
		int expected;
		completed = 1'b0;
		k = 0;
		while (k < samp_run.size() && samp_run[k] != r) begin
			k = k + 1;
		end
		expected = 0;
		for (int i = 0; i < exp_run.size(); i++) begin
			if (exp_run[i] == r) begin
				expected = expected + 1;
			end
		end
		data_valid_i = 1'b0;
		cur_run = r;
		run_outputs = 0;
		quiet = 1'b0;
		trigger_i = 1'b1;
		@(posedge clk);
		#10;
		trigger_i = 1'b0;
		cnt = 0;
		while (!active_o && cnt < 4) begin
			@(posedge clk);
			#10;
			cnt = cnt + 1;
		end
		if (!active_o) begin
			$display("active_o did not rise after the trigger of run %0d", r);
			errors = errors + 1;
		end else begin
			// one lfsr bit per cycle picks sample or gap
			while (k < samp_run.size() && samp_run[k] == r) begin
				lfsr = lfsr_step(lfsr);
				if (lfsr[0]) begin
					data_valid_i = 1'b1;
					data_re_i = sample_part_t'(samp_re[k]);
					data_im_i = sample_part_t'(samp_im[k]);
					k = k + 1;
				end else begin
					data_valid_i = 1'b0;
				end
				@(posedge clk);
				#10;
			end
			data_valid_i = 1'b0;
			cnt = 0;
			while (active_o && cnt < 1000) begin
				@(posedge clk);
				#10;
				cnt = cnt + 1;
			end
			if (active_o) begin
				$display("active_o never fell at the end of run %0d", r);
				errors = errors + 1;
			end else begin
				// final kept bins still leave the pipeline here
				idle_cycles(4);
				compare(run_outputs, expected, $sformatf("output count of run %0d", r));
				quiet = 1'b1;
				idle_cycles(12);
				completed = 1'b1;
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (arstn && proc_data_valid_o && proc_data_ready_i) begin
			if (quiet) begin
				$display("output at %0t ns while no run was open", $time);
				errors = errors + 1;
			end else if (out_idx >= exp_pow.size()) begin
				$display("output at %0t ns beyond the end of the expected list", $time);
				errors = errors + 1;
			end else begin
				compare(cur_run, exp_run[out_idx], $sformatf("run of output %0d", out_idx));
				compare(proc_data_o, exp_pow[out_idx], $sformatf("power %0d", out_idx));
				compare(proc_data_last_o, exp_last[out_idx], $sformatf("last %0d", out_idx));
				out_idx = out_idx + 1;
			end
			run_outputs = run_outputs + 1;
		end
	end

	initial begin
		trigger_i = 1'b0;
		data_re_i = '0;
		data_im_i = '0;
		data_valid_i = 1'b0;
		proc_data_ready_i = 1'b1;
		arstn = 1'b0;
		errors = 0;
		out_idx = 0;
		run_outputs = 0;
		cur_run = -1;
		quiet = 1'b1;
		run_ok = 1'b1;
		lfsr = 32'h2813_1386;
		load_tests();
		repeat (8) @(posedge clk);
		#10;
		arstn = 1'b1;
		// nothing may happen before the first trigger
		idle_cycles(12);
		for (int r = 0; r < num_runs && run_ok; r++) begin
			run_once(r, run_ok);
		end
		finish_sim();
	end

endmodule

`default_nettype wire

// ==== dv/spectrum_frontend_tests.txt ====
# t starts a run, s holds four samples as re im pairs in signed decimal
# e holds the kept bins of one window as power last pairs in decimal
t
s -32768 -32768 3 4 -5 12 8 -15
s 100 0 0 -200 7 24 -20 -21
s 1000 1000 -1 1 32767 0 12 35
s 9 40 -300 400 11 60 2 -2
e 2147483648 0 25 0 169 0 289 0 10000 1
e 10000 0 40000 0 625 0 841 0 2000000 1
e 2000000 0 2 0 1073676289 0 1369 0 1681 1
# the last flag of the final window of a run is dropped in flight
# so bin_select still sits past its kept bins and swallows window 0 here
t
s 1 0 0 1 2 3 -4 5
s 6 -7 -8 -9 10 11 -12 13
s 14 -15 16 17 -18 19 20 -21
s 22 23 -24 25 26 27 28 -29
e 85 0 145 0 221 0 313 0 421 1
e 421 0 545 0 685 0 841 0 1013 1

// ==== spectrum_frontend.f ====
src/fft_frame_pkg.sv
src/sample_stream_if.sv
src/frame_ram.sv
src/stream_register.sv
src/power_calc.sv
src/bin_select.sv
src/frame_sequencer.sv
src/spectrum_frontend.sv
dv/spectrum_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: spectrum_frontend

sources:
  # rtl in compile order
  - files:
      - src/fft_frame_pkg.sv
      - src/sample_stream_if.sv
      - src/frame_ram.sv
      - src/stream_register.sv
      - src/power_calc.sv
      - src/bin_select.sv
      - src/frame_sequencer.sv
      - src/spectrum_frontend.sv

  # testbench for simulation only
  - target: test
    files:
      - dv/spectrum_frontend_tb.sv
